// File: tb/otp_lci_stim.txt
// Columns: op exp payload
// op 1 RESET, 2 ENABLE, 3 REQ, 4 ESC, 5 IDLEWAIT, f END
// exp bit 4 ack expected, bits 2:0 error_o afterwards
// ESC payload bits 3:0 escalation value, bit 8 starts a transition first
// IDLEWAIT payload is a cycle count
1 00 0
5 00 a
3 00 00000001001001001000000300f00a05
2 00 0
5 00 5
3 10 00000001001001001000000300f00a05
3 10 00030001003101041800000300f10a0f
3 10 00030001003101041800000300f10a0f
3 12 00030f01003101041000000300f10a0f
3 02 00030001003101041800000300f10a0f
4 02 5
5 00 8
1 00 0
2 00 0
3 10 00030f01003101041000000300f10a0f
4 03 105
5 00 8
1 00 0
2 00 0
4 03 0
1 00 0
5 00 6
f 00 0

// File: filelist.f
source/otp_macro_pkg.sv
source/otp_lc_pkg.sv
source/otp_macro_if.sv
source/otp_word_counter.sv
source/otp_lci.sv
source/otp_macro_model.sv
source/otp_lci_top.sv
tb/tb_otp_lci_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the OTP life cycle testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_otp_lci_top -o sim \
  && ./obj_dir/sim > sim.log 2>&1 \
  || echo "Build or simulation exited with an error" >> sim.log

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No pass line found in sim.log"; exit 1; }
echo "Simulation passed"

// File: tb/tb_otp_lci_top.sv
`timescale 1ns/100ps

module tb_otp_lci_top;

  ////////////////////////////////////////////////////////////
  // Run geometry
  ////////////////////////////////////////////////////////////

  localparam int ClkHalf     = 50;
  localparam int ResetCycles = 8;
  localparam int MaxRecs     = 64;
  localparam int StimDepth   = 3 * MaxRecs;
  localparam int NumWords    = otp_lc_pkg::LcNumWords;
  // Wait budgets in cycles
  localparam int AckTimeout  = 16 * NumWords;
  localparam int NoAckWindow = 100;
  localparam int EscLead     = 6;
  localparam int EscWindow   = 30;

  // Operation codes of the stimulus file
  localparam logic [3:0] OpReset    = 4'h1;
  localparam logic [3:0] OpEnable   = 4'h2;
  localparam logic [3:0] OpReq      = 4'h3;
  localparam logic [3:0] OpEsc      = 4'h4;
  localparam logic [3:0] OpIdleWait = 4'h5;

  logic                clk_i;
  logic                rst_ni;
  logic                lci_en_i;
  otp_lc_pkg::lc_tx_t  escalate_en_i;
  logic                lc_req_i;
  logic [127:0]        lc_data_i;
  logic                lc_ack_o;
  logic                lc_err_o;
  otp_lc_pkg::otp_err_e error_o;
  logic                fsm_err_o;
  logic                lci_prog_idle_o;

  // Records of op, expected code and payload
  logic [127:0] stim_mem [0:StimDepth-1];

  // Reference OTP image and FSM view
  logic [15:0] image [0:NumWords-1];
  logic        enabled;
  logic        locked;
  logic        esc_active;
  logic [2:0]  err_state;

  int errors      = 0;
  int checks      = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int num_recs    = 0;

  otp_lci_top dut_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o)
  );

  always #ClkHalf clk_i = ~clk_i;

  // Cycle budget guard
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Error: run exceeded the limit of %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks and reference model
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [127:0] exp_val,
                             input logic [127:0] act_val);
    checks++;
    if (act_val !== exp_val) begin
      errors++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h at %0t", name, exp_val, act_val, $time);
    end
  endtask

  // Outputs between operations
  task automatic check_quiet();
    check_value("lc_ack_o", 128'(1'b0), 128'(lc_ack_o));
    check_value("lc_err_o", 128'(1'b0), 128'(lc_err_o));
    check_value("error_o", 128'(err_state), 128'(error_o));
    check_value("fsm_err_o", 128'(esc_active), 128'(fsm_err_o));
    check_value("lci_prog_idle_o", 128'(enabled || locked), 128'(lci_prog_idle_o));
  endtask

  task automatic clear_model();
    for (int w = 0; w < NumWords; w++) begin
      image[w] = 16'h0;
    end
    enabled    = 1'b0;
    locked     = 1'b0;
    esc_active = 1'b0;
    err_state  = otp_lc_pkg::NoError;
  endtask

  // Burn all words, the last failing word sets the code
  task automatic burn_image(input logic [127:0] data, output logic [2:0] err);
    logic [15:0] new_word;
    err = otp_lc_pkg::NoError;
    for (int w = 0; w < NumWords; w++) begin
      new_word = data[w*16 +: 16];
      // Stored one asked to become zero
      if ((image[w] & ~new_word) != 16'h0) begin
        err = otp_lc_pkg::MacroWriteBlankError;
      end
      image[w] = image[w] | new_word;
    end
  endtask

  function automatic logic known_op(input logic [3:0] op);
    return op === OpReset || op === OpEnable || op === OpReq
        || op === OpEsc || op === OpIdleWait;
  endfunction

  ////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni        <= 1'b0;
    lci_en_i      <= 1'b0;
    escalate_en_i <= otp_lc_pkg::Off;
    lc_req_i      <= 1'b0;
    lc_data_i     <= '0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    clear_model();
    @(negedge clk_i);
    check_quiet();
  endtask

  // Idle follows one cycle after enable is seen
  task automatic apply_enable();
    @(posedge clk_i);
    lci_en_i <= 1'b1;
    @(negedge clk_i);
    if (!enabled && !locked) begin
      check_value("lci_prog_idle_o", 128'(1'b0), 128'(lci_prog_idle_o));
    end
    @(posedge clk_i);
    @(negedge clk_i);
    enabled = 1'b1;
    check_value("lci_prog_idle_o", 128'(1'b1), 128'(lci_prog_idle_o));
  endtask

  task automatic apply_request(input logic [127:0] data, input logic [7:0] exp);
    logic [2:0] pred;
    logic       ack_exp;
    logic       got_ack;
    int         wait_cnt;
    ack_exp = enabled && !locked;
    pred    = err_state;
    if (ack_exp) begin
      burn_image(data, pred);
    end
    // File expectation against the reference model
    check_value("stim_ack", 128'(exp[4]), 128'(ack_exp));
    check_value("stim_error", 128'(exp[2:0]), 128'(pred));
    @(posedge clk_i);
    lc_data_i <= data;
    lc_req_i  <= 1'b1;
    if (ack_exp) begin
      got_ack  = 1'b0;
      wait_cnt = 0;
      while (!got_ack && wait_cnt < AckTimeout) begin
        @(negedge clk_i);
        wait_cnt++;
        got_ack = lc_ack_o;
      end
      if (got_ack) begin
        check_value("lc_err_o", 128'(pred != otp_lc_pkg::NoError), 128'(lc_err_o));
      end else begin
        errors++;
        $display("Error: no acknowledge within %0d cycles of the request", AckTimeout);
      end
      if (pred != otp_lc_pkg::NoError) begin
        locked    = 1'b1;
        err_state = pred;
      end
    end else begin
      repeat (NoAckWindow) begin
        @(negedge clk_i);
        check_value("lc_ack_o", 128'(1'b0), 128'(lc_ack_o));
      end
    end
    @(posedge clk_i);
    lc_req_i <= 1'b0;
    @(negedge clk_i);
    check_quiet();
  endtask

  task automatic apply_escalation(input logic [127:0] data, input logic [7:0] exp);
    logic [2:0] pred;
    logic       esc_on;
    esc_on = (data[3:0] != 4'b1010);
    pred   = err_state;
    if (esc_on && err_state == otp_lc_pkg::NoError) begin
      pred = otp_lc_pkg::FsmStateError;
    end
    check_value("stim_error", 128'(exp[2:0]), 128'(pred));
    // Bit 8 lets the escalation land in the middle of a transition
    if (data[8] && enabled && !locked) begin
      @(posedge clk_i);
      lc_req_i <= 1'b1;
      repeat (EscLead) @(posedge clk_i);
    end else begin
      @(posedge clk_i);
    end
    escalate_en_i <= otp_lc_pkg::lc_tx_t'(data[3:0]);
    @(negedge clk_i);
    check_value("fsm_err_o", 128'(esc_on), 128'(fsm_err_o));
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("error_o", 128'(pred), 128'(error_o));
    locked     = locked || esc_on;
    esc_active = esc_on;
    err_state  = pred;
    repeat (EscWindow) begin
      @(negedge clk_i);
      check_value("lc_ack_o", 128'(1'b0), 128'(lc_ack_o));
    end
    @(posedge clk_i);
    lc_req_i <= 1'b0;
    @(negedge clk_i);
    check_quiet();
  endtask

  task automatic wait_idle(input int num_cycles);
    repeat (num_cycles) begin
      @(negedge clk_i);
      check_value("lc_ack_o", 128'(1'b0), 128'(lc_ack_o));
    end
    check_quiet();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    lci_en_i      = 1'b0;
    escalate_en_i = otp_lc_pkg::Off;
    lc_req_i      = 1'b0;
    lc_data_i     = '0;
    clear_model();
    $readmemh("tb/otp_lci_stim.txt", stim_mem);
    // Budget the run from the stimulus lines
    while (num_recs < MaxRecs && known_op(stim_mem[3*num_recs][3:0])) begin
      if (stim_mem[3*num_recs][3:0] == OpReq) begin
        cycle_limit += 16 * NumWords;
      end else begin
        cycle_limit += 50;
      end
      num_recs++;
    end
    if (num_recs == 0) begin
      errors++;
      $display("Error: no stimulus records could be read");
    end
    for (int r = 0; r < num_recs; r++) begin
      case (stim_mem[3*r][3:0])
        OpReset:    apply_reset();
        OpEnable:   apply_enable();
        OpReq:      apply_request(stim_mem[3*r+2], stim_mem[3*r+1][7:0]);
        OpEsc:      apply_escalation(stim_mem[3*r+2], stim_mem[3*r+1][7:0]);
        default:    wait_idle(int'(stim_mem[3*r+2][7:0]));
      endcase
    end
    $display("Records: %0d, checks: %0d, errors: %0d", num_recs, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: source/otp_lci_top.sv
`timescale 1ns/100ps

module otp_lci_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               lci_en_i,
  input  otp_lc_pkg::lc_tx_t                 escalate_en_i,
  input  logic                               lc_req_i,
  input  logic [otp_lc_pkg::LcDataWidth-1:0] lc_data_i,
  output logic                               lc_ack_o,
  output logic                               lc_err_o,
  output otp_lc_pkg::otp_err_e               error_o,
  output logic                               fsm_err_o,
  output logic                               lci_prog_idle_o
);

  // Word request path between FSM and macro
  otp_macro_if macro_if ();

  // Life cycle programming FSM
  otp_lci u_lci (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .lci_en_i        (lci_en_i),
    .escalate_en_i   (escalate_en_i),
    .lc_req_i        (lc_req_i),
    .lc_data_i       (lc_data_i),
    .lc_ack_o        (lc_ack_o),
    .lc_err_o        (lc_err_o),
    .error_o         (error_o),
    .fsm_err_o       (fsm_err_o),
    .lci_prog_idle_o (lci_prog_idle_o),
    .macro_o         (macro_if.requester)
  );

  // Behavioural OTP array
  otp_macro_model u_macro_model (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .macro_i (macro_if.macro)
  );

endmodule

// File: source/otp_macro_model.sv
`timescale 1ns/100ps

module otp_macro_model (
  input  logic      clk_i,
  input  logic      rst_ni,
  otp_macro_if.macro macro_i
);

  // OTP array, blank is all zeros
  otp_macro_pkg::otp_word_t mem_q [otp_macro_pkg::OtpDepth];

  // One bit per cycle of response delay
  logic [otp_macro_pkg::OtpRespLatency-1:0] resp_pipe_q;

  // Status of the transfer in flight
  otp_macro_pkg::macro_err_e err_q;

  logic pending;
  logic xfer;
  logic is_write;
  logic blank_fail;
  otp_macro_pkg::otp_word_t old_word;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Only one transfer at a time
  assign pending     = |resp_pipe_q;
  assign macro_i.gnt = !pending;
  assign xfer        = macro_i.req && macro_i.gnt;
  assign is_write    = (macro_i.cmd == otp_macro_pkg::Write);

  // Programmed bits can not return to zero
  assign old_word   = mem_q[macro_i.addr];
  assign blank_fail = is_write && (|(old_word & ~macro_i.wdata));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_pipe_q <= '0;
      err_q       <= otp_macro_pkg::NoError;
    end else begin
      resp_pipe_q <= {resp_pipe_q[otp_macro_pkg::OtpRespLatency-2:0], xfer};
      if (xfer) begin
        err_q <= blank_fail ? otp_macro_pkg::MacroWriteBlankError
                            : otp_macro_pkg::NoError;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Word array
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < otp_macro_pkg::OtpDepth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (xfer && is_write) begin
      // Burning can only add ones
      mem_q[macro_i.addr] <= old_word | macro_i.wdata;
    end
  end

  // Response pulse at the end of the delay line
  assign macro_i.rvalid = resp_pipe_q[otp_macro_pkg::OtpRespLatency-1];
  assign macro_i.err    = macro_i.rvalid ? err_q : otp_macro_pkg::NoError;

  // Requests arrive with known command, address and data
  ReqKnown_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    macro_i.req |-> !$isunknown({macro_i.cmd, macro_i.addr, macro_i.wdata})
  );

  // Grant stays low right after a transfer
  NoGntWhileBusy_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $past(xfer) |-> !macro_i.gnt
  );

endmodule

// File: source/otp_lci.sv
`timescale 1ns/100ps

module otp_lci (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               lci_en_i,
  input  otp_lc_pkg::lc_tx_t                 escalate_en_i,
  input  logic                               lc_req_i,
  input  logic [otp_lc_pkg::LcDataWidth-1:0] lc_data_i,
  output logic                               lc_ack_o,
  output logic                               lc_err_o,
  output otp_lc_pkg::otp_err_e               error_o,
  output logic                               fsm_err_o,
  output logic                               lci_prog_idle_o,
  otp_macro_if.requester                     macro_o
);

  typedef enum logic [2:0] {
    ResetSt,
    IdleSt,
    WriteSt,
    WriteWaitSt,
    ErrorSt
  } state_e;

  state_e state_d, state_q;
  otp_lc_pkg::otp_err_e error_d, error_q, rsp_err;
  otp_lc_pkg::lc_cnt_t cnt;
  logic cnt_clr, cnt_en, cnt_err, esc_asserted;
  logic otp_req;
  otp_macro_pkg::cmd_e otp_cmd;

  // Partition viewed as native words
  otp_macro_pkg::otp_word_t [otp_lc_pkg::LcNumWords-1:0] words;

  assign words        = lc_data_i;
  assign esc_asserted = otp_lc_pkg::lc_tx_asserted(escalate_en_i);
  assign rsp_err      = otp_lc_pkg::otp_err_e'(macro_o.err);
  assign error_o      = error_q;

  ////////////////////////////////////////////////////////////
  // Programming FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    error_d         = error_q;
    cnt_clr         = 1'b0;
    cnt_en          = 1'b0;
    otp_req         = 1'b0;
    otp_cmd         = otp_macro_pkg::Read;
    lc_ack_o        = 1'b0;
    lc_err_o        = 1'b0;
    fsm_err_o       = 1'b0;
    lci_prog_idle_o = 1'b1;

    case (state_q)
      // Hold off until the controller is enabled
      ResetSt: begin
        lci_prog_idle_o = 1'b0;
        if (lci_en_i) begin
          state_d = IdleSt;
        end
      end
      // Wait for a transition, restart at word zero
      IdleSt: begin
        if (lc_req_i) begin
          cnt_clr = 1'b1;
          state_d = WriteSt;
        end
      end
      // Present one word write until the macro grants it
      WriteSt: begin
        lci_prog_idle_o = 1'b0;
        otp_req         = 1'b1;
        otp_cmd         = otp_macro_pkg::Write;
        if (macro_o.gnt) begin
          state_d = WriteWaitSt;
        end
      end
      // Collect the response and pick the next word
      WriteWaitSt: begin
        lci_prog_idle_o = 1'b0;
        if (macro_o.rvalid) begin
          // Keep the latest failure, but burn all remaining words
          if (rsp_err != otp_lc_pkg::NoError) begin
            error_d = rsp_err;
          end
          if (cnt == otp_lc_pkg::LcLastWord) begin
            lc_ack_o = 1'b1;
            state_d  = IdleSt;
            // Any failure locks the partition
            if (error_d != otp_lc_pkg::NoError) begin
              lc_err_o = 1'b1;
              state_d  = ErrorSt;
            end
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteSt;
          end
        end
      end
      // Terminal state, always report something
      ErrorSt: begin
        if (error_q == otp_lc_pkg::NoError) begin
          error_d = otp_lc_pkg::FsmStateError;
        end
      end
      // Glitched encoding, lock down at once
      default: begin
        fsm_err_o = 1'b1;
        state_d   = ErrorSt;
        if (error_q == otp_lc_pkg::NoError) begin
          error_d = otp_lc_pkg::FsmStateError;
        end
      end
    endcase

    // Escalation or a counter mismatch overrides everything
    if (esc_asserted || cnt_err) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      lc_ack_o  = 1'b0;
      lc_err_o  = 1'b0;
      // Keep an earlier macro code visible
      if (error_d == otp_lc_pkg::NoError) begin
        error_d = otp_lc_pkg::FsmStateError;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      error_q <= otp_lc_pkg::NoError;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Word counter and macro request
  ////////////////////////////////////////////////////////////

  otp_word_counter u_word_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .clr_i     (cnt_clr),
    .incr_en_i (cnt_en),
    .cnt_o     (cnt),
    .err_o     (cnt_err)
  );

  assign macro_o.req  = otp_req;
  assign macro_o.cmd  = otp_cmd;
  // Partition base word plus the current count
  assign macro_o.addr = otp_macro_pkg::otp_addr_t'(otp_lc_pkg::LcWordOffset)
                      + otp_macro_pkg::otp_addr_t'(cnt);
  assign macro_o.wdata = otp_req ? words[cnt] : '0;

  // Status outputs never go unknown once out of reset
  OutputsKnown_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({lc_ack_o, lc_err_o, error_o, fsm_err_o, lci_prog_idle_o, otp_req})
  );

  // A pending write holds address and data until granted
  ReqStable_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni || esc_asserted || cnt_err)
    (otp_req && !macro_o.gnt) |=>
      (otp_req && $stable(macro_o.addr) && $stable(macro_o.wdata))
  );

  // Ack answers a held request, one response latency after the last grant
  AckAfterLastGnt_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    lc_ack_o |->
      (state_q == WriteWaitSt && lc_req_i
       && $past(otp_req && macro_o.gnt, otp_macro_pkg::OtpRespLatency))
  );

endmodule

// File: source/otp_word_counter.sv
`timescale 1ns/100ps

module otp_word_counter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clr_i,
  input  logic                incr_en_i,
  output otp_lc_pkg::lc_cnt_t cnt_o,
  output logic                err_o
);

  // Primary copy counts up from zero
  otp_lc_pkg::lc_cnt_t up_d, up_q;
  // Shadow copy counts down from all ones
  otp_lc_pkg::lc_cnt_t dn_d, dn_q;

  always_comb begin
    up_d = up_q;
    dn_d = dn_q;
    if (clr_i) begin
      up_d = '0;
      dn_d = '1;
    end else if (incr_en_i) begin
      up_d = up_q + otp_lc_pkg::lc_cnt_t'(1);
      dn_d = dn_q - otp_lc_pkg::lc_cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      up_q <= '0;
      dn_q <= '1;
    end else begin
      up_q <= up_d;
      dn_q <= dn_d;
    end
  end

  assign cnt_o = up_q;

  // Shadow must always hold the complement of the primary
  assign err_o = (up_q != ~dn_q);

  // FSM never clears and steps in the same cycle
  ClrIncrExclusive_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(clr_i && incr_en_i)
  );

endmodule

// File: source/otp_macro_if.sv
`timescale 1ns/100ps

interface otp_macro_if;

  // Request side
  logic                      req;
  otp_macro_pkg::cmd_e       cmd;
  otp_macro_pkg::otp_addr_t  addr;
  otp_macro_pkg::otp_word_t  wdata;

  // Grant and response side
  logic                      gnt;
  logic                      rvalid;
  otp_macro_pkg::macro_err_e err;

  // Programming FSM end
  modport requester (
    output req, cmd, addr, wdata,
    input  gnt, rvalid, err
  );

  // OTP macro end
  modport macro (
    input  req, cmd, addr, wdata,
    output gnt, rvalid, err
  );

endinterface

// File: source/otp_lc_pkg.sv
package otp_lc_pkg;

  ////////////////////////////////////////////////////////////
  // Partition geometry
  ////////////////////////////////////////////////////////////

  // Life cycle partition size and its byte offset in the macro
  localparam int LcPartSizeBytes = 16;
  localparam int LcPartOffset    = 'h40;
  localparam int LcDataWidth     = LcPartSizeBytes * 8;

  // Number of native 16-bit words in the partition
  localparam int LcNumWords = LcPartSizeBytes >> otp_macro_pkg::OtpAddrShift;
  localparam int LcCntWidth = $clog2(LcNumWords);

  // Word address of the first partition word
  localparam int LcWordOffset = LcPartOffset >> otp_macro_pkg::OtpAddrShift;

  typedef logic [LcCntWidth-1:0] lc_cnt_t;

  // Index of the final word of a transition
  localparam lc_cnt_t LcLastWord = lc_cnt_t'(LcNumWords - 1);

  ////////////////////////////////////////////////////////////
  // Escalation and error codes
  ////////////////////////////////////////////////////////////

  // Multibit escalation value, only Off means quiet
  typedef enum logic [3:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lc_tx_t;

  // Anything but Off is treated as an active escalation
  function automatic logic lc_tx_asserted(lc_tx_t val);
    return val != Off;
  endfunction

  typedef enum logic [2:0] {
    NoError              = 3'h0,
    MacroError           = 3'h1,
    MacroWriteBlankError = 3'h2,
    FsmStateError        = 3'h3
  } otp_err_e;

endpackage

// File: source/otp_macro_pkg.sv
package otp_macro_pkg;

  ////////////////////////////////////////////////////////////
  // Macro geometry and timing
  ////////////////////////////////////////////////////////////

  // Native word and word address widths
  localparam int OtpWidth     = 16;
  localparam int OtpAddrWidth = 10;

  // Byte address to word address shift
  localparam int OtpAddrShift = 1;

  // Number of words in the macro array
  localparam int OtpDepth = 2 ** OtpAddrWidth;

  // Cycles from transfer to response valid
  localparam int OtpRespLatency = 2;

  typedef logic [OtpWidth-1:0]     otp_word_t;
  typedef logic [OtpAddrWidth-1:0] otp_addr_t;

  ////////////////////////////////////////////////////////////
  // Command and error encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    Read  = 1'b0,
    Write = 1'b1
  } cmd_e;

  // Values line up with the life cycle error codes
  typedef enum logic [2:0] {
    NoError              = 3'h0,
    MacroWriteBlankError = 3'h2
  } macro_err_e;

endpackage
